//--- sources.f
axi_lite_pkg.sv
meta_fifo.sv
axi_to_axi_lite.sv
axi_lite_regfile.sv
axi_lite_subsys_top.sv
tb_clk_gen.sv
tb_axi_lite_subsys.sv

//--- Bender.yml
package:
  name: axi_lite_subsys

sources:
  - axi_lite_pkg.sv
  - meta_fifo.sv
  - axi_to_axi_lite.sv
  - axi_lite_regfile.sv
  - axi_lite_subsys_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_axi_lite_subsys.sv

//--- tb_axi_lite_subsys.sv
// Testbench for the AXI4 to AXI4-Lite register subsystem
// Random single-beat traffic against a register model, checked by assertions
module tb_axi_lite_subsys;

  import axi_lite_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_PAIRS    = 80;
  localparam int NUM_UNMAPPED = 16;
  // Two sweeps of plain reads plus a write and a read per pair
  localparam int NUM_TXN      = 2 * REG_COUNT + 2 * NUM_PAIRS + 2 * NUM_UNMAPPED;
  localparam int TXN_CYCLES   = 20;
  localparam int WATCHDOG     = NUM_TXN * TXN_CYCLES * CLK_PERIOD;

  logic    clk_i;
  logic    rst_n_i;
  axi_aw_t aw_i;
  logic    aw_valid_i;
  logic    aw_ready_o;
  axi_w_t  w_i;
  logic    w_valid_i;
  logic    w_ready_o;
  axi_b_t  b_o;
  logic    b_valid_o;
  logic    b_ready_i;
  axi_ar_t ar_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  axi_r_t  r_o;
  logic    r_valid_o;
  logic    r_ready_i;

  integer seed    = 32'hff2a0bf9;
  int     err_cnt = 0;

  // Register model and the responses still owed by the DUT, oldest first
  logic [DATA_WIDTH-1:0] model [REG_COUNT];
  axi_b_t                exp_b_q [$];
  axi_r_t                exp_r_q [$];
  axi_b_t                exp_b_head;
  axi_r_t                exp_r_head;
  logic                  b_pending;
  logic                  r_pending;

  tb_clk_gen #(
    .PERIOD (CLK_PERIOD)
  ) tb_clk_gen_inst (
    .clk_o (clk_i)
  );

  axi_lite_subsys_top axi_lite_subsys_top_inst (
    .clk_i, .rst_n_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i
  );

  task automatic count_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  // Drive one AW and its W beat together and hold them until accepted
  task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [31:0] rnd;
    axi_aw_t     aw;
    axi_w_t      w;
    rnd     = $random(seed);
    aw.id   = rnd[ID_WIDTH-1:0];
    aw.user = rnd[8 +: USER_WIDTH];
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    aw_i       <= aw;
    w_i        <= w;
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  task automatic issue_read(input logic [31:0] addr);
    logic [31:0] rnd;
    axi_ar_t     ar;
    rnd     = $random(seed);
    ar.id   = rnd[ID_WIDTH-1:0];
    ar.user = rnd[8 +: USER_WIDTH];
    ar.addr = addr;
    ar_i       <= ar;
    ar_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    ar_valid_i <= 1'b0;
  endtask

  // Sampled on the falling edge where the model bookkeeping has settled
  task automatic drain_responses();
    do @(negedge clk_i); while (b_pending || r_pending);
  endtask

  // Responses are stalled at random, about half of the cycles
  initial begin : ready_stall
    logic [31:0] rnd;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    forever begin
      // The next stall pattern is picked between edges and applied on the rising edge
      @(negedge clk_i);
      rnd = $random(seed);
      @(posedge clk_i);
      b_ready_i <= rst_n_i & rnd[0];
      r_ready_i <= rst_n_i & rnd[1];
    end
  end

  // Reference model fed from the accepted requests
  always @(posedge clk_i) begin : ref_model
    axi_b_t b_exp;
    axi_r_t r_exp;
    if (!rst_n_i) begin
      exp_b_q.delete();
      exp_r_q.delete();
      for (int i = 0; i < REG_COUNT; i++) begin
        model[i] = '0;
      end
    end else begin
      if (b_valid_o && b_ready_i && exp_b_q.size() != 0) begin
        void'(exp_b_q.pop_front());
      end
      if (r_valid_o && r_ready_i && exp_r_q.size() != 0) begin
        void'(exp_r_q.pop_front());
      end
      // A read in the same cycle as a write still sees the old contents
      if (ar_valid_i && ar_ready_o) begin
        r_exp.id   = ar_i.id;
        r_exp.user = ar_i.user;
        r_exp.last = 1'b1;
        r_exp.resp = (ar_i.addr < 32'h10) ? RESP_OKAY : RESP_SLVERR;
        r_exp.data = (ar_i.addr < 32'h10) ? model[ar_i.addr[3:2]] : '0;
        exp_r_q.push_back(r_exp);
      end
      if (aw_valid_i && aw_ready_o) begin
        b_exp.id   = aw_i.id;
        b_exp.user = aw_i.user;
        b_exp.resp = (aw_i.addr < 32'h10) ? RESP_OKAY : RESP_SLVERR;
        if (aw_i.addr < 32'h10) begin
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (w_i.strb[b]) begin
              model[aw_i.addr[3:2]][8*b +: 8] = w_i.data[8*b +: 8];
            end
          end
        end
        exp_b_q.push_back(b_exp);
      end
    end
    b_pending = (exp_b_q.size() != 0);
    r_pending = (exp_r_q.size() != 0);
    if (b_pending) exp_b_head = exp_b_q[0];
    if (r_pending) exp_r_head = exp_r_q[0];
  end

  // The slave only takes a write when address and data are both offered
  aw_idle_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !aw_valid_i |-> !aw_ready_o)
  else count_error("aw_ready_o was high without a write address on offer");

  w_idle_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !w_valid_i |-> !w_ready_o)
  else count_error("w_ready_o was high without write data on offer");

  // Address and data of a write are always taken in the same cycle
  aw_w_pair_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_ready_o == w_ready_o)
  else count_error("aw_ready_o and w_ready_o were not raised together");

  b_latency_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(aw_valid_i && aw_ready_o) |-> b_valid_o)
  else count_error("Write response did not follow one cycle after the accepted write");

  r_latency_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(ar_valid_i && ar_ready_o) |-> r_valid_o)
  else count_error("Read data did not follow one cycle after the accepted read");

  b_hold_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(b_valid_o && !b_ready_i) |-> (b_valid_o && $stable(b_o)))
  else count_error("Write response dropped or changed while b_ready_i was low");

  r_hold_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(r_valid_o && !r_ready_i) |-> (r_valid_o && $stable(r_o)))
  else count_error("Read data dropped or changed while r_ready_i was low");

  b_block_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (b_valid_o && !b_ready_i) |-> !aw_ready_o)
  else count_error("A second write was accepted while a write response was stalled");

  r_block_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_o && !r_ready_i) |-> !ar_ready_o)
  else count_error("A second read was accepted while read data was stalled");

  b_payload_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o |-> (b_pending && b_o == exp_b_head))
  else count_error($sformatf("ERROR b_o: got %h, expected %h",
                             $sampled(b_o), $sampled(exp_b_head)));

  r_payload_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o |-> (r_pending && r_o == exp_r_head))
  else count_error($sformatf("ERROR r_o: got %h, expected %h",
                             $sampled(r_o), $sampled(exp_r_head)));

  r_last_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o |-> r_o.last)
  else count_error("ERROR r_o.last: got 0, expected 1");

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    rst_n_i    = 1'b0;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // Nothing may be pending or ready for a write straight out of reset
    assert (!b_valid_o && !r_valid_o)
    else count_error("A response valid was high right after reset");
    assert (!aw_ready_o && !w_ready_o)
    else count_error("A write ready was high right after reset");

    // All registers start at zero
    for (int i = 0; i < REG_COUNT; i++) begin
      issue_read(32'(i * 4));
    end

    // Strobed writes, each read back from the same register
    for (int i = 0; i < NUM_PAIRS; i++) begin
      rnd  = $random(seed);
      addr = {28'h0, rnd[1:0], 2'b00};
      data = $random(seed);
      rnd  = $random(seed);
      issue_write(addr, data, rnd[3:0]);
      issue_read(addr);
    end

    // Unmapped space answers with an error and leaves the model alone
    for (int i = 0; i < NUM_UNMAPPED; i++) begin
      rnd  = $random(seed);
      addr = rnd | 32'h0000_0010;
      data = $random(seed);
      rnd  = $random(seed);
      issue_write(addr, data, rnd[3:0]);
      issue_read(addr);
    end

    // Final sweep shows the unmapped writes did not land anywhere
    for (int i = 0; i < REG_COUNT; i++) begin
      issue_read(32'(i * 4));
    end

    drain_responses();
    $display("Checks finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Bounds the run if a handshake never completes
  initial begin : watchdog
    #(WATCHDOG);
    $display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG / CLK_PERIOD);
    $display("Checks finished with %0d errors", err_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
// Testbench clock source for the register subsystem
// Free-running clock that starts low
module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    // Half a period high and half a period low
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

//--- axi_lite_subsys_top.sv
// Register subsystem top, AXI4 slave port in front of the Lite regfile
module axi_lite_subsys_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_lite_pkg::axi_aw_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_lite_pkg::axi_w_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi_lite_pkg::axi_b_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  axi_lite_pkg::axi_ar_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_lite_pkg::axi_r_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  import axi_lite_pkg::*;

  // Lite channels between the adapter and the register slave
  lite_ax_t lite_aw;
  logic     lite_aw_valid;
  logic     lite_aw_ready;
  axi_w_t   lite_w;
  logic     lite_w_valid;
  logic     lite_w_ready;
  lite_b_t  lite_b;
  logic     lite_b_valid;
  logic     lite_b_ready;
  lite_ax_t lite_ar;
  logic     lite_ar_valid;
  logic     lite_ar_ready;
  lite_r_t  lite_r;
  logic     lite_r_valid;
  logic     lite_r_ready;

  axi_to_axi_lite axi_to_axi_lite_inst (
    .clk_i, .rst_n_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .lite_aw_o (lite_aw), .lite_aw_valid_o (lite_aw_valid), .lite_aw_ready_i (lite_aw_ready),
    .lite_w_o  (lite_w),  .lite_w_valid_o  (lite_w_valid),  .lite_w_ready_i  (lite_w_ready),
    .lite_b_i  (lite_b),  .lite_b_valid_i  (lite_b_valid),  .lite_b_ready_o  (lite_b_ready),
    .lite_ar_o (lite_ar), .lite_ar_valid_o (lite_ar_valid), .lite_ar_ready_i (lite_ar_ready),
    .lite_r_i  (lite_r),  .lite_r_valid_i  (lite_r_valid),  .lite_r_ready_o  (lite_r_ready)
  );

  axi_lite_regfile axi_lite_regfile_inst (
    .clk_i, .rst_n_i,
    .aw_i (lite_aw), .aw_valid_i (lite_aw_valid), .aw_ready_o (lite_aw_ready),
    .w_i  (lite_w),  .w_valid_i  (lite_w_valid),  .w_ready_o  (lite_w_ready),
    .b_o  (lite_b),  .b_valid_o  (lite_b_valid),  .b_ready_i  (lite_b_ready),
    .ar_i (lite_ar), .ar_valid_i (lite_ar_valid), .ar_ready_o (lite_ar_ready),
    .r_o  (lite_r),  .r_valid_o  (lite_r_valid),  .r_ready_i  (lite_r_ready)
  );

endmodule

//--- axi_lite_regfile.sv
// AXI4-Lite slave with four 32-bit control registers
// Byte-strobed writes, SLVERR and zero data outside the mapped range
module axi_lite_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_lite_pkg::lite_ax_t aw_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  axi_lite_pkg::axi_w_t   w_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output axi_lite_pkg::lite_b_t  b_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  input  axi_lite_pkg::lite_ax_t ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  output axi_lite_pkg::lite_r_t  r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  import axi_lite_pkg::*;

  logic [DATA_WIDTH-1:0] regs_q [REG_COUNT];

  // Write channel state
  logic                  wr_fire;
  logic                  wr_mapped;
  logic [1:0]            wr_idx;
  logic                  b_valid_q;
  logic [1:0]            b_resp_q;

  // Read channel state
  logic                  rd_fire;
  logic                  rd_mapped;
  logic [1:0]            rd_idx;
  logic                  r_valid_q;
  logic [DATA_WIDTH-1:0] r_data_q;
  logic [1:0]            r_resp_q;

  // Registers sit at a 4-byte stride from address zero
  assign wr_mapped = (aw_i.addr < ADDR_WIDTH'(REG_COUNT * 4));
  assign rd_mapped = (ar_i.addr < ADDR_WIDTH'(REG_COUNT * 4));
  assign wr_idx    = aw_i.addr[3:2];
  assign rd_idx    = ar_i.addr[3:2];

  // Address and data are taken together, and only once the previous
  // B has left so a single response register is enough
  assign wr_fire    = aw_valid_i & w_valid_i & ~b_valid_q;
  assign aw_ready_o = wr_fire;
  assign w_ready_o  = wr_fire;

  // One read in flight at a time
  assign ar_ready_o = ~r_valid_q;
  assign rd_fire    = ar_valid_i & ar_ready_o;

  // Register array with per-byte write enables
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_fire && wr_mapped) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (w_i.strb[b]) begin
          regs_q[wr_idx][8*b +: 8] <= w_i.data[8*b +: 8];
        end
      end
    end
  end

  // B valid rises the cycle after the write and drops on b_ready
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_fire) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  // Response code is captured with the write and held until taken
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // R valid follows the same pattern as B
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_fire) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Unmapped reads return zero data
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= rd_mapped ? regs_q[rd_idx] : '0;
      r_resp_q <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_o.resp  = b_resp_q;
  assign r_valid_o = r_valid_q;
  assign r_o.data  = r_data_q;
  assign r_o.resp  = r_resp_q;

endmodule

//--- axi_to_axi_lite.sv
// AXI4 to AXI4-Lite adapter for single-beat traffic
// Stores ID/USER per request in FIFOs and puts them back on B and R
module axi_to_axi_lite (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // AXI4 slave side
  input  axi_lite_pkg::axi_aw_t    aw_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  axi_lite_pkg::axi_w_t     w_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  output axi_lite_pkg::axi_b_t     b_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  input  axi_lite_pkg::axi_ar_t    ar_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  output axi_lite_pkg::axi_r_t     r_o,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  // AXI4-Lite master side
  output axi_lite_pkg::lite_ax_t   lite_aw_o,
  output logic                     lite_aw_valid_o,
  input  logic                     lite_aw_ready_i,
  output axi_lite_pkg::axi_w_t     lite_w_o,
  output logic                     lite_w_valid_o,
  input  logic                     lite_w_ready_i,
  input  axi_lite_pkg::lite_b_t    lite_b_i,
  input  logic                     lite_b_valid_i,
  output logic                     lite_b_ready_o,
  output axi_lite_pkg::lite_ax_t   lite_ar_o,
  output logic                     lite_ar_valid_o,
  input  logic                     lite_ar_ready_i,
  input  axi_lite_pkg::lite_r_t    lite_r_i,
  input  logic                     lite_r_valid_i,
  output logic                     lite_r_ready_o
);

  import axi_lite_pkg::*;

  logic  wr_full;
  logic  rd_full;
  meta_t wr_meta;
  meta_t rd_meta;

  // Write side metadata, pushed on every accepted AW and
  // released when its B response completes
  meta_fifo #(
    .DEPTH (2 ** $clog2(NUM_PENDING_WR))
  ) wr_meta_fifo_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_valid_i & aw_ready_o),
    .data_i  ('{id: aw_i.id, user: aw_i.user}),
    .pop_i   (b_valid_o & b_ready_i),
    .data_o  (wr_meta),
    .full_o  (wr_full),
    .empty_o ()
  );

  // Read side metadata, popped on the last R beat
  // Every beat is last here since bursts are not split
  meta_fifo #(
    .DEPTH (2 ** $clog2(NUM_PENDING_RD))
  ) rd_meta_fifo_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (ar_valid_i & ar_ready_o),
    .data_i  ('{id: ar_i.id, user: ar_i.user}),
    .pop_i   (r_valid_o & r_ready_i & r_o.last),
    .data_o  (rd_meta),
    .full_o  (rd_full),
    .empty_o ()
  );

  // Requests pass only while there is room to remember their metadata
  // A full FIFO also hides the request from the Lite slave
  assign aw_ready_o      = ~wr_full & lite_aw_ready_i;
  assign lite_aw_valid_o = ~wr_full & aw_valid_i;
  assign lite_aw_o.addr  = aw_i.addr;

  assign ar_ready_o      = ~rd_full & lite_ar_ready_i;
  assign lite_ar_valid_o = ~rd_full & ar_valid_i;
  assign lite_ar_o.addr  = ar_i.addr;

  // Write data is the same on both sides
  assign lite_w_o       = w_i;
  assign lite_w_valid_o = w_valid_i;
  assign w_ready_o      = lite_w_ready_i;

  // Responses carry the head metadata of the matching FIFO
  assign b_o.id         = wr_meta.id;
  assign b_o.resp       = lite_b_i.resp;
  assign b_o.user       = wr_meta.user;
  assign b_valid_o      = lite_b_valid_i;
  assign lite_b_ready_o = b_ready_i;

  assign r_o.id         = rd_meta.id;
  assign r_o.data       = lite_r_i.data;
  assign r_o.resp       = lite_r_i.resp;
  assign r_o.last       = 1'b1;
  assign r_o.user       = rd_meta.user;
  assign r_valid_o      = lite_r_valid_i;
  assign lite_r_ready_o = r_ready_i;

endmodule

//--- meta_fifo.sv
// Small in-order FIFO for reflected ID/USER metadata
// Circular buffer with an occupancy counter, head entry always visible
module meta_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  axi_lite_pkg::meta_t data_i,
  input  logic                pop_i,
  output axi_lite_pkg::meta_t data_o,
  output logic                full_o,
  output logic                empty_o
);

  import axi_lite_pkg::*;

  // A single entry still needs a one-bit pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  meta_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // Requests against a full or empty buffer are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // The oldest entry sits at the read pointer
  assign data_o = mem[rd_ptr_q];

  // Storage only, the counter tells which slots hold valid data
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // Wrap explicitly so any depth works
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the occupancy alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- axi_lite_pkg.sv
// Shared definitions for the AXI4 to AXI4-Lite register subsystem
// Holds bus widths, pending limits, the register map and channel structs
package axi_lite_pkg;

  // Bus widths shared by the AXI4 side and the AXI4-Lite side
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Widths of the fields that only exist on the AXI4 side
  localparam int ID_WIDTH   = 4;
  localparam int USER_WIDTH = 2;

  // Maximum outstanding transactions per direction
  // The adapter rounds these up to a power of two for its metadata FIFOs
  localparam int NUM_PENDING_RD = 2;
  localparam int NUM_PENDING_WR = 2;

  // Number of 32-bit registers in the slave, at a stride of 4 bytes
  localparam int REG_COUNT = 4;

  // AXI response encodings that the slave can return
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Request fields that the Lite side cannot carry and that travel back
  // with the response
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [USER_WIDTH-1:0] user;
  } meta_t;

  // AXI4 write address request
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [USER_WIDTH-1:0] user;
  } axi_aw_t;

  // AXI4 read address request, same layout as the write side
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [USER_WIDTH-1:0] user;
  } axi_ar_t;

  // Write data beat, identical on AXI4 and AXI4-Lite
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } axi_w_t;

  // AXI4 write response
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [1:0]            resp;
    logic [USER_WIDTH-1:0] user;
  } axi_b_t;

  // AXI4 read data beat
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
    logic [USER_WIDTH-1:0] user;
  } axi_r_t;

  // AXI4-Lite address, used on both AW and AR
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } lite_ax_t;

  // AXI4-Lite write response
  typedef struct packed {
    logic [1:0] resp;
  } lite_b_t;

  // AXI4-Lite read data beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
  } lite_r_t;

endpackage
